// ==== hdl/cordic_cfg.svh ====
`ifndef CORDIC_CFG_SVH
`define CORDIC_CFG_SVH

// pipeline depth in micro-rotations
`define CORDIC_STAGES 12

// fixed point formats, total width and fraction bits
`define ANGLE_IN_W    8
`define ANGLE_IN_FRAC 6
`define ANGLE_W       16
`define ANGLE_FRAC    12
`define VEC_W         16
`define VEC_FRAC      13
`define OUT_W         8
`define OUT_FRAC      6

// 0.60725 scaled by 2^13, start value of x
`define CORDIC_GAIN   4975

`define FIFO_DEPTH    16

`define AXIL_ADDR_W   4
`define AXIL_DATA_W   32

`define REG_ANGLE     4'h0
`define REG_RESULT    4'h4
`define REG_STATUS    4'h8

`define AXI_OKAY      2'b00
`define AXI_SLVERR    2'b10

`endif

// ==== hdl/cordic_pipeline.sv ====
`timescale 1ns/1ps

`include "cordic_cfg.svh"

module cordic_pipeline
    import cordic_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  angle_in_t  angle,
    output logic       done,
    output trig_pair_t result
);

    // input angle to residual format
    localparam int ALIGN    = `ANGLE_FRAC - `ANGLE_IN_FRAC;
    // vector format down to output format
    localparam int RND_SH   = `VEC_FRAC - `OUT_FRAC;
    localparam vec_t RND_HALF = vec_t'(1 << (RND_SH - 1));

    rot_state_t chain [`CORDIC_STAGES+1];

    angle_t angle_ext;
    angle_t angle_mag;
    vec_t   x_rnd;
    vec_t   y_rnd;
    trig_t  sin_mag;

    assign angle_ext = angle_t'(angle);
    assign angle_mag = angle_ext[`ANGLE_W-1] ? -angle_ext : angle_ext;

    // fold stage, rotate the magnitude and remember the sign
    always_ff @(posedge clk) begin
        chain[0].neg <= angle[`ANGLE_IN_W-1];
        chain[0].x   <= vec_t'(`CORDIC_GAIN);
        chain[0].y   <= '0;
        chain[0].z   <= angle_mag <<< ALIGN;

        if (!rst_n) begin
            chain[0].valid <= 1'b0;
        end else begin
            chain[0].valid <= start;
        end
    end

    for (genvar i = 0; i < `CORDIC_STAGES; i++) begin : g_stage
        cordic_stage #(
            .STAGE(i)
        ) stage_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .stage_in (chain[i]),
            .stage_out(chain[i+1])
        );
    end

    // round half up, then drop the extra fraction bits
    assign x_rnd   = chain[`CORDIC_STAGES].x + RND_HALF;
    assign y_rnd   = chain[`CORDIC_STAGES].y + RND_HALF;
    assign sin_mag = trig_t'(y_rnd >>> RND_SH);

    // cosine is even, only sine takes the sign back
    always_ff @(posedge clk) begin
        result.cosine <= trig_t'(x_rnd >>> RND_SH);
        result.sine   <= chain[`CORDIC_STAGES].neg ? -sin_mag : sin_mag;

        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= chain[`CORDIC_STAGES].valid;
        end
    end

endmodule

// ==== hdl/cordic_pkg.sv ====
`include "cordic_cfg.svh"

package cordic_pkg;

    typedef logic signed [`ANGLE_IN_W-1:0] angle_in_t;
    typedef logic signed [`ANGLE_W-1:0]    angle_t;
    typedef logic signed [`VEC_W-1:0]      vec_t;
    typedef logic signed [`OUT_W-1:0]      trig_t;

    // state carried from one rotation stage to the next
    typedef struct packed {
        logic   valid;
        logic   neg;
        vec_t   x;
        vec_t   y;
        angle_t z;
    } rot_state_t;

    typedef struct packed {
        trig_t sine;
        trig_t cosine;
    } trig_pair_t;

    // master side of the AXI4-Lite port
    typedef struct packed {
        logic                     awvalid;
        logic [`AXIL_ADDR_W-1:0]  awaddr;
        logic                     wvalid;
        logic [`AXIL_DATA_W-1:0]  wdata;
        logic [`AXIL_DATA_W/8-1:0] wstrb;
        logic                     bready;
        logic                     arvalid;
        logic [`AXIL_ADDR_W-1:0]  araddr;
        logic                     rready;
    } axil_req_t;

    // slave side of the AXI4-Lite port
    typedef struct packed {
        logic                    awready;
        logic                    wready;
        logic                    bvalid;
        logic [1:0]              bresp;
        logic                    arready;
        logic                    rvalid;
        logic [`AXIL_DATA_W-1:0] rdata;
        logic [1:0]              rresp;
    } axil_rsp_t;

    typedef enum logic {
        RD_IDLE,
        RD_RESP
    } rd_state_t;

    // atan(2^-idx) with 12 fraction bits
    function automatic angle_t atan_lut(input int unsigned idx);
        case (idx)
            0:       return angle_t'(3217);
            1:       return angle_t'(1899);
            2:       return angle_t'(1003);
            3:       return angle_t'(509);
            4:       return angle_t'(256);
            5:       return angle_t'(128);
            6:       return angle_t'(64);
            7:       return angle_t'(32);
            8:       return angle_t'(16);
            9:       return angle_t'(8);
            10:      return angle_t'(4);
            11:      return angle_t'(2);
            default: return '0;
        endcase
    endfunction

endpackage

// ==== hdl/cordic_regs.sv ====
`timescale 1ns/1ps

`include "cordic_cfg.svh"

module cordic_regs
    import cordic_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  axil_req_t                       axil_in,
    output axil_rsp_t                       axil_out,
    output logic                            start,
    output angle_in_t                       angle,
    input  trig_pair_t                      fifo_head,
    input  logic [$clog2(`FIFO_DEPTH):0]    fifo_level,
    output logic                            pop
);

    localparam int LVL_W = $clog2(`FIFO_DEPTH) + 1;

    logic [LVL_W-1:0]        credits;
    logic [LVL_W-1:0]        in_flight;
    logic                    wr_is_angle;
    logic                    credit_free;
    logic                    wr_accept;
    logic                    rd_accept;
    logic                    bvalid_q;
    logic [1:0]              bresp_q;
    logic                    arready_q;
    logic [`AXIL_DATA_W-1:0] rdata_q;
    logic [1:0]              rresp_q;
    logic [`AXIL_DATA_W-1:0] rd_word;
    logic [1:0]              rd_resp;
    rd_state_t               rd_state;
    rd_state_t               rd_next;

    // address and data are taken together
    assign wr_is_angle = axil_in.awaddr == `REG_ANGLE;
    assign credit_free = credits < LVL_W'(`FIFO_DEPTH);
    assign wr_accept   = axil_in.awvalid && axil_in.wvalid &&
                         (!bvalid_q || axil_in.bready) &&
                         (!wr_is_angle || credit_free);

    // launch goes straight into the fold stage
    assign start = wr_accept && wr_is_angle && axil_in.wstrb[0];
    assign angle = angle_in_t'(axil_in.wdata[`ANGLE_IN_W-1:0]);

    // one credit per result either in flight or queued
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= '0;
        end else begin
            case ({start, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign in_flight = credits - fifo_level;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
        end else if (wr_accept) begin
            bvalid_q <= 1'b1;
        end else if (axil_in.bready) begin
            bvalid_q <= 1'b0;
        end
        if (wr_accept) begin
            bresp_q <= wr_is_angle ? `AXI_OKAY : `AXI_SLVERR;
        end
    end

    // read side
    assign rd_accept = axil_in.arvalid && arready_q;
    assign pop       = rd_accept && (axil_in.araddr == `REG_RESULT) && (fifo_level != '0);

    always_comb begin
        rd_word = '0;
        rd_resp = `AXI_OKAY;
        case (axil_in.araddr)
            `REG_RESULT: begin
                if (fifo_level != '0) begin
                    rd_word[7:0]                = fifo_head.sine;
                    rd_word[15:8]               = fifo_head.cosine;
                    rd_word[`AXIL_DATA_W-1]     = 1'b1;
                end
            end
            `REG_STATUS: begin
                rd_word[LVL_W-1:0] = fifo_level;
                rd_word[8 +: LVL_W] = in_flight;
            end
            default: rd_resp = `AXI_SLVERR;
        endcase
    end

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: if (rd_accept) rd_next = RD_RESP;
            RD_RESP: if (axil_in.rready) rd_next = RD_IDLE;
            default: rd_next = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state  <= RD_IDLE;
            arready_q <= 1'b0;
        end else begin
            rd_state  <= rd_next;
            arready_q <= rd_next == RD_IDLE;
        end
        if (rd_accept) begin
            rdata_q <= rd_word;
            rresp_q <= rd_resp;
        end
    end

    always_comb begin
        axil_out.awready = wr_accept;
        axil_out.wready  = wr_accept;
        axil_out.bvalid  = bvalid_q;
        axil_out.bresp   = bresp_q;
        axil_out.arready = arready_q;
        axil_out.rvalid  = rd_state == RD_RESP;
        axil_out.rdata   = rdata_q;
        axil_out.rresp   = rresp_q;
    end

endmodule

// ==== hdl/cordic_stage.sv ====
`timescale 1ns/1ps

module cordic_stage
    import cordic_pkg::*;
#(
    parameter int STAGE = 0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  rot_state_t stage_in,
    output rot_state_t stage_out
);

    localparam angle_t ATAN = atan_lut(STAGE);

    vec_t   x_in;
    vec_t   y_in;
    vec_t   x_sh;
    vec_t   y_sh;
    logic   rot_pos;

    // local signed copies so the shifts stay arithmetic
    assign x_in    = stage_in.x;
    assign y_in    = stage_in.y;
    assign x_sh    = x_in >>> STAGE;
    assign y_sh    = y_in >>> STAGE;
    assign rot_pos = ~stage_in.z[$bits(angle_t)-1];

    always_ff @(posedge clk) begin
        // residual angle still positive, rotate counter-clockwise
        if (rot_pos) begin
            stage_out.x <= x_in - y_sh;
            stage_out.y <= y_in + x_sh;
            stage_out.z <= stage_in.z - ATAN;
        end else begin
            stage_out.x <= x_in + y_sh;
            stage_out.y <= y_in - x_sh;
            stage_out.z <= stage_in.z + ATAN;
        end
        stage_out.neg <= stage_in.neg;

        if (!rst_n) begin
            stage_out.valid <= 1'b0;
        end else begin
            stage_out.valid <= stage_in.valid;
        end
    end

endmodule

// ==== hdl/cordic_top.sv ====
`timescale 1ns/1ps

`include "cordic_cfg.svh"

module cordic_top
    import cordic_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  axil_req_t axil_in,
    output axil_rsp_t axil_out
);

    logic                          start;
    angle_in_t                     angle;
    logic                          done;
    trig_pair_t                    result;
    trig_pair_t                    fifo_head;
    logic [$clog2(`FIFO_DEPTH):0]  fifo_level;
    logic                          pop;

    // host interface and credit keeping
    cordic_regs regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .axil_in   (axil_in),
        .axil_out  (axil_out),
        .start     (start),
        .angle     (angle),
        .fifo_head (fifo_head),
        .fifo_level(fifo_level),
        .pop       (pop)
    );

    cordic_pipeline pipeline_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .angle (angle),
        .done  (done),
        .result(result)
    );

    // push side never stalls, credits keep it from overflowing
    result_fifo #(
        .DEPTH(`FIFO_DEPTH)
    ) fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (done),
        .push_data(result),
        .pop      (pop),
        .head     (fifo_head),
        .level    (fifo_level)
    );

endmodule

// ==== hdl/result_fifo.sv ====
`timescale 1ns/1ps

module result_fifo
    import cordic_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  trig_pair_t             push_data,
    input  logic                   pop,
    output trig_pair_t             head,
    output logic [$clog2(DEPTH):0] level
);

    localparam int PTR_W = $clog2(DEPTH);

    trig_pair_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_pop;

    // popping an empty fifo is ignored
    assign do_pop = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head is valid only while level is non-zero
    assign head  = mem[rd_ptr];
    assign level = count;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_cordic -o tb_cordic &&
./obj_dir/tb_cordic ||
{ echo "simulation did not pass" >&2; exit 1; }

// ==== verif/tb_cordic.sv ====
`timescale 1ns/1ps

`include "cordic_cfg.svh"

module tb_cordic
    import cordic_pkg::*;
();

    localparam int N_ACC       = 40;
    localparam int N_SYM       = 12;
    localparam int N_BP        = 20;
    localparam int N_LAT       = 3;
    localparam int N_TRANS     = 2 * N_ACC + 4 * N_SYM + 2 * N_BP + 8 * N_LAT + 8;
    localparam int TIMEOUT_CYC = N_TRANS * 40 + 2000;
    localparam int WAIT_MAX    = 64;

    logic      clk = 1'b0;
    logic      rst_n;
    axil_req_t req;
    axil_rsp_t rsp;
    int        cycle = 0;
    int        seed;

    cordic_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .axil_in (req),
        .axil_out(rsp)
    );

    always #5 clk = ~clk;

    // edge counter, used to time handshakes
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        stop_on_error();
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else fail_run(what);
    endtask

    task automatic check_equal(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            stop_on_error();
        end
    endtask

    // trig outputs may be off by up to 2 lsb
    task automatic check_close(input string name, input int expected, input int actual);
        assert (actual >= expected - 2 && actual <= expected + 2) else begin
            $display("mismatch %s: expected %0d +/- 2, actual %0d", name, expected, actual);
            stop_on_error();
        end
    endtask

    function automatic int ref_sin(input int a);
        real v;
        v = $sin(real'(a) / 64.0) * 64.0;
        return $rtoi($floor(v + 0.5));
    endfunction

    function automatic int ref_cos(input int a);
        real v;
        v = $cos(real'(a) / 64.0) * 64.0;
        return $rtoi($floor(v + 0.5));
    endfunction

    // legal range is -100..100
    function automatic int random_angle();
        return $random(seed) % 101;
    endfunction

    task automatic write_start(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= 4'hf;
    endtask

    // acc_cyc is the number of the edge that takes the write
    task automatic write_wait(input int max_cycles, output bit accepted, output int acc_cyc);
        accepted = 1'b0;
        acc_cyc  = 0;
        for (int i = 0; i < max_cycles && !accepted; i++) begin
            @(negedge clk);
            if (rsp.awready && rsp.wready) begin
                accepted = 1'b1;
                acc_cyc  = cycle + 1;
            end
        end
    endtask

    task automatic write_finish(output logic [1:0] resp);
        int n;
        n = 0;
        @(posedge clk);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        req.bready  <= 1'b1;
        @(negedge clk);
        while (!rsp.bvalid && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        check_true(rsp.bvalid, "no write response arrived");
        resp = rsp.bresp;
        @(posedge clk);
        req.bready <= 1'b0;
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output logic [1:0] resp, output int acc_cyc);
        bit accepted;
        write_start(addr, data);
        write_wait(WAIT_MAX, accepted, acc_cyc);
        check_true(accepted, "write address was never accepted");
        write_finish(resp);
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] resp, output int acc_cyc);
        int n;
        n = 0;
        @(posedge clk);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        @(negedge clk);
        while (!rsp.arready && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        check_true(rsp.arready, "read address was never accepted");
        acc_cyc = cycle + 1;
        @(posedge clk);
        req.arvalid <= 1'b0;
        req.rready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!rsp.rvalid && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        check_true(rsp.rvalid, "no read data arrived");
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        req.rready <= 1'b0;
    endtask

    // poll RESULT until an entry comes back
    task automatic read_result(output int sine, output int cosine);
        logic [31:0] data;
        logic [1:0]  resp;
        int          acc_cyc;
        int          n;
        n = 0;
        do begin
            axil_read(`REG_RESULT, data, resp, acc_cyc);
            n++;
        end while (!data[31] && n < WAIT_MAX);
        check_true(data[31], "no result appeared in the FIFO");
        check_equal("result rresp", `AXI_OKAY, resp);
        sine   = int'($signed(data[7:0]));
        cosine = int'($signed(data[15:8]));
    endtask

    task automatic launch(input int a);
        logic [1:0] resp;
        int         acc_cyc;
        axil_write(`REG_ANGLE, {24'h0, 8'(a)}, resp, acc_cyc);
        check_equal("angle bresp", `AXI_OKAY, resp);
    endtask

    task automatic check_trig(input string name, input int a, input int sine, input int cosine);
        check_close($sformatf("%s sine a=%0d", name, a), ref_sin(a), sine);
        check_close($sformatf("%s cosine a=%0d", name, a), ref_cos(a), cosine);
    endtask

    initial begin
        int          s;
        int          c;
        int          s_neg;
        int          c_neg;
        int          a;
        int          wr_cyc;
        int          rd_cyc;
        int          elapsed;
        int          exp_level;
        int          angles[$];
        bit          accepted;
        bit          got_level;
        logic [31:0] data;
        logic [1:0]  resp;

        seed  = 32'hf731a8a5;
        rst_n <= 1'b0;
        req   <= '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < N_ACC; i++) begin
            a = random_angle();
            launch(a);
            read_result(s, c);
            check_trig("accuracy", a, s, c);
        end

        // sine is odd, cosine even
        for (int i = 0; i < N_SYM; i++) begin
            a = random_angle();
            if (a < 0) begin
                a = -a;
            end
            launch(a);
            read_result(s, c);
            launch(-a);
            read_result(s_neg, c_neg);
            check_equal($sformatf("symmetry sine a=%0d", a), -s, s_neg);
            check_equal($sformatf("symmetry cosine a=%0d", a), c, c_neg);
        end

        // a STATUS read sees the level of the edge before its acceptance
        for (int phase = 0; phase < N_LAT; phase++) begin
            axil_write(`REG_ANGLE, {24'h0, 8'd37}, resp, wr_cyc);
            // status polls land three cycles apart, each pass starts one cycle later
            repeat (phase) @(posedge clk);
            got_level = 1'b0;
            for (int i = 0; i < WAIT_MAX && !got_level; i++) begin
                axil_read(`REG_STATUS, data, resp, rd_cyc);
                elapsed   = rd_cyc - 1 - wr_cyc;
                exp_level = (elapsed >= 14) ? 1 : 0;
                check_equal($sformatf("latency level at %0d", elapsed), exp_level,
                            int'(data[4:0]));
                check_equal($sformatf("latency in-flight at %0d", elapsed), 1 - exp_level,
                            int'(data[12:8]));
                got_level = data[4:0] == 5'd1;
            end
            check_true(got_level, "latency result never reached the FIFO");
            read_result(s, c);
            check_trig("latency", 37, s, c);
        end

        for (int i = 0; i < N_BP; i++) begin
            angles.push_back(random_angle());
        end
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            launch(angles[i]);
        end
        write_start(`REG_ANGLE, {24'h0, 8'(angles[16])});
        write_wait(30, accepted, wr_cyc);
        check_true(!accepted, "17th angle write accepted with all credits taken");
        read_result(s, c);
        check_trig("ordering #0", angles[0], s, c);
        // the pop frees one credit for the waiting write
        write_finish(resp);
        check_equal("17th write bresp", `AXI_OKAY, resp);
        for (int i = 1; i < N_BP; i++) begin
            read_result(s, c);
            check_trig($sformatf("ordering #%0d", i), angles[i], s, c);
            if (i + 16 < N_BP) begin
                launch(angles[i + 16]);
            end
        end

        axil_read(`REG_RESULT, data, resp, rd_cyc);
        check_equal("empty result word", 0, int'(data));
        axil_write(4'hc, 32'h0000_0011, resp, wr_cyc);
        check_equal("unmapped write bresp", `AXI_SLVERR, resp);
        axil_read(`REG_STATUS, data, resp, rd_cyc);
        check_equal("status after unmapped write", 0, int'(data));
        axil_read(4'hc, data, resp, rd_cyc);
        check_equal("unmapped read word", 0, int'(data));
        check_equal("unmapped read rresp", `AXI_SLVERR, resp);

        $display("Test completed successfully");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles", TIMEOUT_CYC);
        stop_on_error();
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/cordic_pkg.sv
hdl/cordic_stage.sv
hdl/cordic_pipeline.sv
hdl/result_fifo.sv
hdl/cordic_regs.sv
hdl/cordic_top.sv
verif/tb_cordic.sv
